/* logic/wb_pkg.sv */
//----------------------------------------------------------
// wishbone classic bus types
// request and response words for a single-beat read master,
// plus the bus widths shared by master and slave
//----------------------------------------------------------

`default_nettype none

package wb_pkg;

	localparam int WB_ADDR_W = 16;	// bit 15 picks the right image
	localparam int WB_DATA_W = 8;	// one grey pixel per beat

	// master to slave
	typedef struct packed {
		logic                 cyc;	// bus cycle in progress
		logic                 stb;	// strobe, valid transfer
		logic                 we;	// write enable, reads only here
		logic [WB_ADDR_W-1:0] adr;	// {image select, row*WIDTH+col}
		logic [WB_DATA_W-1:0] dat;	// write data, tied off
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic                 ack;	// one-cycle acknowledge
		logic [WB_DATA_W-1:0] dat;	// read data, valid with ack
	} wb_rsp_t;

endpackage

`default_nettype wire

/* logic/stereo_pkg.sv */
//----------------------------------------------------------
// stereo matching types
// pixel and sum widths, and the words passed between
// the fetch, accumulate and select stages
//----------------------------------------------------------

`default_nettype none

package stereo_pkg;

	typedef logic [7:0]  pixel_t;	// grey level
	typedef logic [19:0] ssd_t;	// holds 9 * 255^2
	typedef logic [3:0]  disp_t;	// offset index for MAX_DISP up to 15
	typedef logic [7:0]  coord_t;	// row or column index

	// one window tap from fetch to accumulate
	typedef struct packed {
		logic   valid;
		pixel_t left;		// left image at window position
		pixel_t right;		// right image shifted by offset
		disp_t  offset;
		logic   last_tap;	// ninth tap of this offset
		logic   last_offset;	// offset == MAX_DISP
		logic   line_end;	// pixel is last of its row
		logic   frame_end;	// pixel is last of the frame
	} tap_t;

	// completed window sum of one offset for the select stage
	typedef struct packed {
		logic  valid;
		ssd_t  ssd;
		disp_t offset;
		logic  last_offset;
		logic  line_end;
		logic  frame_end;
	} cand_t;

	// scaled result for one pixel in raster order
	typedef struct packed {
		logic   valid;
		pixel_t value;		// best offset * (255 / MAX_DISP)
		logic   line_end;	// last result of a row
		logic   frame_end;	// last result of the frame
	} disp_out_t;

endpackage

`default_nettype wire

/* logic/window_fetch.sv */
//----------------------------------------------------------
// window fetch stage
// walks pixel, offset and 3x3 tap, reading the left and
// right pixel of every tap over a wishbone classic master;
// the position flags for the later stages are made here
//----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module window_fetch #(
	parameter int WIDTH    = 16,
	parameter int HEIGHT   = 8,
	parameter int MAX_DISP = 5
) (
	input  logic             HCLK,
	input  logic             HRESETn,
	input  logic             start,	// frame start pulse
	output logic             busy,
	output wb_pkg::wb_req_t  wb_req,
	input  wb_pkg::wb_rsp_t  wb_rsp,
	output stereo_pkg::tap_t tap
);
	import wb_pkg::*;
	import stereo_pkg::*;

	localparam int LIN_W = WB_ADDR_W - 1;	// linear pixel index width
	localparam coord_t ROW_FIRST = coord_t'(1);
	localparam coord_t ROW_LAST  = coord_t'(HEIGHT - 2);
	localparam coord_t COL_FIRST = coord_t'(MAX_DISP + 1);	// every offset fits
	localparam coord_t COL_LAST  = coord_t'(WIDTH - 2);
	localparam disp_t  OFF_LAST  = disp_t'(MAX_DISP);
	localparam logic [LIN_W-1:0] ROW_PITCH = LIN_W'(WIDTH);

	typedef enum logic [1:0] {
		S_IDLE,		// wait for start
		S_RD_L,		// left pixel read
		S_RD_R,		// gap cycle then right pixel read
		S_EMIT		// tap out and counters advance
	} state_t;

	state_t           state;
	logic             req_on;	// drives cyc and stb
	coord_t           row;
	coord_t           col;
	disp_t            offset;
	logic [1:0]       wx;		// tap column in window
	logic [1:0]       wy;		// tap row in window
	pixel_t           left_q;
	pixel_t           right_q;
	logic [1:0]       drain;	// busy tail while the last pixel drains
	logic             ack;
	coord_t           win_row;
	coord_t           win_col;
	coord_t           rgt_col;
	logic [LIN_W-1:0] left_lin;
	logic [LIN_W-1:0] right_lin;
	logic             last_tap;
	logic             last_offset;
	logic             line_end;
	logic             frame_end;
	logic             final_tap;

	//----------------------------------------------------------
	// position and address
	//----------------------------------------------------------
	assign win_row = row + coord_t'(wy) - coord_t'(1);
	assign win_col = col + coord_t'(wx) - coord_t'(1);
	assign rgt_col = win_col - coord_t'(offset);	// >= 0 since col > MAX_DISP

	assign left_lin  = LIN_W'(win_row) * ROW_PITCH + LIN_W'(win_col);
	assign right_lin = LIN_W'(win_row) * ROW_PITCH + LIN_W'(rgt_col);

	assign last_tap    = (wx == 2'd2) && (wy == 2'd2);
	assign last_offset = (offset == OFF_LAST);
	assign line_end    = (col == COL_LAST);
	assign frame_end   = line_end && (row == ROW_LAST);
	assign final_tap   = last_tap && last_offset && frame_end;

	assign ack = req_on && wb_rsp.ack;

	//----------------------------------------------------------
	// walk FSM
	//----------------------------------------------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state  <= S_IDLE;
			req_on <= 1'b0;
			row    <= ROW_FIRST;
			col    <= COL_FIRST;
			offset <= '0;
			wx     <= '0;
			wy     <= '0;
		end else begin
			case (state)
			S_IDLE: begin
				if (start && !busy) begin	// start ignored while busy
					state  <= S_RD_L;
					req_on <= 1'b1;
					row    <= ROW_FIRST;
					col    <= COL_FIRST;
					offset <= '0;
					wx     <= '0;
					wy     <= '0;
				end
			end
			S_RD_L: begin
				if (ack) begin
					req_on <= 1'b0;	// stb low the cycle after ack
					state  <= S_RD_R;
				end
			end
			S_RD_R: begin
				if (!req_on)
					req_on <= 1'b1;	// right address now on the bus
				else if (ack) begin
					req_on <= 1'b0;
					state  <= S_EMIT;
				end
			end
			S_EMIT: begin
				if (!last_tap) begin
					wx <= (wx == 2'd2) ? 2'd0 : wx + 2'd1;
					wy <= (wx == 2'd2) ? wy + 2'd1 : wy;
				end else begin
					wx <= '0;
					wy <= '0;
					offset <= last_offset ? '0 : offset + disp_t'(1);
					if (last_offset) begin	// pixel done so step the raster
						col <= line_end ? COL_FIRST : col + coord_t'(1);
						if (line_end)
							row <= frame_end ? ROW_FIRST : row + coord_t'(1);
					end
				end
				state  <= final_tap ? S_IDLE : S_RD_L;
				req_on <= !final_tap;
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// read data capture
	always_ff @(posedge HCLK) begin
		if (ack && state == S_RD_L)
			left_q <= wb_rsp.dat;
		if (ack && state == S_RD_R)
			right_q <= wb_rsp.dat;
	end

	// busy covers accumulate and select of the final pixel
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn)
			drain <= '0;
		else
			drain <= {drain[0], (state == S_EMIT) && final_tap};
	end

	assign busy = (state != S_IDLE) || (drain != 2'b00);

	//----------------------------------------------------------
	// outputs
	//----------------------------------------------------------
	assign wb_req.cyc = req_on;
	assign wb_req.stb = req_on;
	assign wb_req.we  = 1'b0;
	assign wb_req.adr = (state == S_RD_R) ? {1'b1, right_lin} : {1'b0, left_lin};
	assign wb_req.dat = '0;

	assign tap.valid       = (state == S_EMIT);	// cycle after right ack
	assign tap.left        = left_q;
	assign tap.right       = right_q;
	assign tap.offset      = offset;
	assign tap.last_tap    = last_tap;
	assign tap.last_offset = last_offset;
	assign tap.line_end    = line_end;
	assign tap.frame_end   = frame_end;

	// stb and cyc drop in the cycle after ack
	a_ack_drop: assert property (@(posedge HCLK) disable iff (!HRESETn)
		wb_req.stb && wb_rsp.ack |=> !wb_req.stb && !wb_req.cyc)
		else $error("stb or cyc held past ack");

	// a pending transfer keeps stb and a steady address until ack
	a_adr_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
		wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr))
		else $error("address moved during a pending read");

endmodule

`default_nettype wire

/* logic/ssd_accum.sv */
//----------------------------------------------------------
// ssd accumulate stage
// squares the left/right difference of each tap and sums
// the nine taps of one offset into a candidate
//----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module ssd_accum (
	input  logic              HCLK,
	input  logic              HRESETn,
	input  stereo_pkg::tap_t  tap,
	output stereo_pkg::cand_t cand
);
	import stereo_pkg::*;

	localparam int SSD_W = $bits(ssd_t);
	localparam int SQ_W  = 2 * $bits(pixel_t);

	pixel_t         diff;
	logic [SQ_W-1:0] sq;
	logic [SSD_W:0] sum_wide;	// extra bit shows a wrap
	ssd_t           acc;		// running sum of this offset
	logic           cand_valid;
	ssd_t           cand_ssd;
	disp_t          cand_off;
	logic           cand_last_off;
	logic           cand_line_end;
	logic           cand_frame_end;

	assign diff     = (tap.left > tap.right) ? tap.left - tap.right : tap.right - tap.left;
	assign sq       = SQ_W'(diff) * SQ_W'(diff);
	assign sum_wide = {1'b0, acc} + (SSD_W + 1)'(sq);

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			acc        <= '0;
			cand_valid <= 1'b0;
		end else begin
			cand_valid <= tap.valid && tap.last_tap;	// one cycle after last tap
			if (tap.valid)
				acc <= tap.last_tap ? '0 : sum_wide[SSD_W-1:0];	// clear for next offset
		end
	end

	// candidate payload, flags forwarded from fetch
	always_ff @(posedge HCLK) begin
		if (tap.valid && tap.last_tap) begin
			cand_ssd       <= sum_wide[SSD_W-1:0];
			cand_off       <= tap.offset;
			cand_last_off  <= tap.last_offset;
			cand_line_end  <= tap.line_end;
			cand_frame_end <= tap.frame_end;
		end
	end

	assign cand.valid       = cand_valid;
	assign cand.ssd         = cand_ssd;
	assign cand.offset      = cand_off;
	assign cand.last_offset = cand_last_off;
	assign cand.line_end    = cand_line_end;
	assign cand.frame_end   = cand_frame_end;

	a_no_wrap: assert property (@(posedge HCLK) disable iff (!HRESETn)
		tap.valid |-> !sum_wide[SSD_W])
		else $error("window sum overflowed");

endmodule

`default_nettype wire

/* logic/disparity_select.sv */
//----------------------------------------------------------
// disparity select stage
// keeps the lowest window sum over the offsets of a pixel
// and emits the winning offset scaled to 0..255
//----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module disparity_select #(
	parameter int MAX_DISP = 5
) (
	input  logic                  HCLK,
	input  logic                  HRESETn,
	input  stereo_pkg::cand_t     cand,
	output stereo_pkg::disp_out_t disp_out
);
	import stereo_pkg::*;

	localparam int PIX_W  = $bits(pixel_t);
	localparam int PROD_W = $bits(disp_t) + PIX_W;
	localparam int SCALE  = 255 / MAX_DISP;	// integer quotient
	localparam logic [PROD_W-1:0] SCALE_W = PROD_W'(SCALE);
	localparam logic [PROD_W-1:0] PIX_MAX = PROD_W'(255);

	ssd_t              best_ssd;	// lowest sum so far
	disp_t             best_off;
	logic              take;
	disp_t             win_off;	// winner including this candidate
	logic              out_valid;
	disp_t             out_off;
	logic              out_line_end;
	logic              out_frame_end;
	logic [PROD_W-1:0] scaled;

	// offset 0 always loads; later ones need a strictly lower sum
	assign take    = (cand.offset == '0) || (cand.ssd < best_ssd);
	assign win_off = take ? cand.offset : best_off;

	always_ff @(posedge HCLK) begin
		if (cand.valid && take) begin
			best_ssd <= cand.ssd;
			best_off <= cand.offset;
		end
		if (cand.valid && cand.last_offset) begin	// pixel complete
			out_off       <= win_off;
			out_line_end  <= cand.line_end;
			out_frame_end <= cand.frame_end;
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn)
			out_valid <= 1'b0;
		else
			out_valid <= cand.valid && cand.last_offset;
	end

	//----------------------------------------------------------
	// scaled output
	//----------------------------------------------------------
	assign scaled = PROD_W'(out_off) * SCALE_W;

	assign disp_out.valid     = out_valid;
	assign disp_out.value     = scaled[PIX_W-1:0];
	assign disp_out.line_end  = out_line_end;
	assign disp_out.frame_end = out_frame_end;

	// the registered winner must stay within the search range
	a_in_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
		out_valid |-> scaled <= PIX_MAX)
		else $error("scaled disparity above 255");

endmodule

`default_nettype wire

/* logic/stereo_match_top.sv */
//----------------------------------------------------------
// stereo block-matching disparity engine
// fetch, accumulate and select in a chain; pixels come in
// over wishbone, one scaled disparity per pixel goes out
//----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module stereo_match_top #(
	parameter int WIDTH    = 16,	// image width in pixels
	parameter int HEIGHT   = 8,	// image height in rows
	parameter int MAX_DISP = 5	// largest offset searched
) (
	input  logic                  HCLK,
	input  logic                  HRESETn,
	input  logic                  start,
	output logic                  busy,
	output wb_pkg::wb_req_t       wb_req,
	input  wb_pkg::wb_rsp_t       wb_rsp,
	output stereo_pkg::disp_out_t disp_out
);
	import stereo_pkg::*;

	tap_t  tap;	// fetch -> accumulate
	cand_t cand;	// accumulate -> select

	window_fetch #(
		.WIDTH    (WIDTH),
		.HEIGHT   (HEIGHT),
		.MAX_DISP (MAX_DISP)
	) window_fetch_i (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.start   (start),
		.busy    (busy),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.tap     (tap)
	);

	ssd_accum ssd_accum_i (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.tap     (tap),
		.cand    (cand)
	);

	disparity_select #(
		.MAX_DISP (MAX_DISP)
	) disparity_select_i (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.cand     (cand),
		.disp_out (disp_out)
	);

endmodule

`default_nettype wire

/* verif/image_mem_model.sv */
//----------------------------------------------------------
// image memory model
// wishbone classic slave, left image in the lower half and
// right image in the upper half of the address map; each
// read is acknowledged after 0 to 3 random wait cycles
//----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module image_mem_model (
	input  logic            HCLK,
	input  logic            HRESETn,
	input  wb_pkg::wb_req_t wb_req,
	output wb_pkg::wb_rsp_t wb_rsp
);
	import wb_pkg::*;

	localparam int DEPTH = 2 ** WB_ADDR_W;	// full address map, bit 15 = right

	logic [WB_DATA_W-1:0] mem [0:DEPTH-1];	// loaded by the testbench
	logic                 ack_q;
	logic [WB_DATA_W-1:0] dat_q;
	logic                 pending;	// wait count already drawn for this read
	int                   wait_cnt;
	int                   dly;
	int                   seed = 63;

	// registered ack, so a zero wait still answers one cycle after stb
	always @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			ack_q    <= 1'b0;
			pending  <= 1'b0;
			wait_cnt <= 0;
		end else begin
			ack_q <= 1'b0;	// ack lasts one cycle
			if (wb_req.cyc && wb_req.stb && !ack_q) begin
				dly = pending ? wait_cnt : ($unsigned($random(seed)) % 4);
				if (dly == 0) begin
					ack_q   <= 1'b1;
					dat_q   <= mem[wb_req.adr];	// adr is stable while stb waits
					pending <= 1'b0;
				end else begin
					pending  <= 1'b1;
					wait_cnt <= dly - 1;
				end
			end
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = dat_q;

endmodule

`default_nettype wire

/* verif/stereo_match_tb.sv */
//----------------------------------------------------------
// stereo matcher testbench
// builds left/right test images in a wishbone memory model,
// runs whole frames and checks every disparity, in raster
// order, against a reference search over the same images
//----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module stereo_match_tb;
	import wb_pkg::*;
	import stereo_pkg::*;

	localparam int WIDTH       = 16;
	localparam int HEIGHT      = 8;
	localparam int MAX_DISP    = 5;
	localparam int SHIFT       = 3;	// column shift of the matched pair
	localparam int NUM_RESULTS = (HEIGHT - 2) * (WIDTH - MAX_DISP - 2);
	localparam int RIGHT_BASE  = 1 << (WB_ADDR_W - 1);
	localparam int FRAME_LIMIT = 200000;	// cycle limit well above a full frame
	localparam int RISE_LIMIT  = 20;
	localparam int IMG_SHIFTED = 0;
	localparam int IMG_RANDOM  = 1;
	localparam int IMG_FLAT    = 2;

	logic      HCLK;
	logic      HRESETn;
	logic      start;
	logic      busy;
	wb_req_t   wb_req;
	wb_rsp_t   wb_rsp;
	disp_out_t disp_out;

	pixel_t    left_img  [HEIGHT][WIDTH];
	pixel_t    right_img [HEIGHT][WIDTH];
	disp_out_t expected [$];	// raster order
	disp_out_t want;
	int        result_count = 0;
	int        seed = 63;

	stereo_match_top #(
		.WIDTH    (WIDTH),
		.HEIGHT   (HEIGHT),
		.MAX_DISP (MAX_DISP)
	) stereo_match_top_i (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.start    (start),
		.busy     (busy),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.disp_out (disp_out)
	);

	image_mem_model image_mem_model_i (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp)
	);

	initial begin
		HCLK = 1'b0;
		forever #50 HCLK = ~HCLK;	// 100 ns period
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	//----------------------------------------------------------
	// reference search where the lowest offset wins a tie
	//----------------------------------------------------------
	function automatic int ref_disp(input int r, input int c);
		int best_ssd;
		int best_d;
		int ssd;
		int diff;
		best_ssd = 0;
		best_d   = 0;
		for (int d = 0; d <= MAX_DISP; d++) begin
			ssd = 0;
			for (int dy = -1; dy <= 1; dy++)
				for (int dx = -1; dx <= 1; dx++) begin
					diff = int'(left_img[r + dy][c + dx])
						- int'(right_img[r + dy][c + dx - d]);
					ssd += diff * diff;
				end
			if (d == 0 || ssd < best_ssd) begin
				best_ssd = ssd;
				best_d   = d;
			end
		end
		return best_d * (255 / MAX_DISP);	// integer scale
	endfunction

	task automatic make_images(input int kind);
		pixel_t flat;
		int     idx;
		flat = pixel_t'($random(seed));
		for (int r = 0; r < HEIGHT; r++)
			for (int c = 0; c < WIDTH; c++) begin
				left_img[r][c]  = (kind == IMG_FLAT) ? flat : pixel_t'($random(seed));
				right_img[r][c] = (kind == IMG_FLAT) ? flat : pixel_t'($random(seed));
			end
		if (kind == IMG_SHIFTED)	// right sees the left scene moved by SHIFT
			for (int r = 0; r < HEIGHT; r++)
				for (int c = 0; c < WIDTH - SHIFT; c++)
					right_img[r][c] = left_img[r][c + SHIFT];
		for (int r = 0; r < HEIGHT; r++)
			for (int c = 0; c < WIDTH; c++) begin
				idx = r * WIDTH + c;
				image_mem_model_i.mem[16'(idx)]              = left_img[r][c];
				image_mem_model_i.mem[16'(RIGHT_BASE + idx)] = right_img[r][c];
			end
	endtask

	// known >= 0 also checks that the image pair gives that value everywhere
	task automatic build_expected(input int known);
		disp_out_t item;
		int        v;
		for (int r = 1; r <= HEIGHT - 2; r++)
			for (int c = MAX_DISP + 1; c <= WIDTH - 2; c++) begin
				v = ref_disp(r, c);
				if (known >= 0)
					assert (v == known)
						else fail_run($sformatf(
							"** Error at %0t: reference %0d at row %0d col %0d, expected %0d",
							$time, v, r, c, known));
				item.valid     = 1'b1;
				item.value     = pixel_t'(v);
				item.line_end  = (c == WIDTH - 2);	// last result of the row
				item.frame_end = (c == WIDTH - 2) && (r == HEIGHT - 2);
				expected.push_back(item);
			end
	endtask

	//----------------------------------------------------------
	// comparison at the falling edge where outputs are stable
	//----------------------------------------------------------
	always @(negedge HCLK) begin
		if (HRESETn && wb_req.cyc)	// the master only reads
			assert (!wb_req.we && wb_req.dat == '0)
				else fail_run($sformatf("** Error at %0t: we %0b dat %0h on a read",
					$time, wb_req.we, wb_req.dat));
		if (HRESETn && disp_out.valid) begin
			assert (expected.size() != 0)
				else fail_run($sformatf("** Error at %0t: result %0d with none expected",
					$time, disp_out.value));
			want = expected.pop_front();
			assert (disp_out.value == want.value && disp_out.line_end == want.line_end
				&& disp_out.frame_end == want.frame_end)
				else fail_run($sformatf(
					"** Error at %0t: got %0d le %0b fe %0b, expected %0d le %0b fe %0b",
					$time, disp_out.value, disp_out.line_end, disp_out.frame_end,
					want.value, want.line_end, want.frame_end));
			result_count++;
		end
	end

	task automatic run_frame(input int kind, input bit extra_start);
		int cycles;
		int first;
		make_images(kind);
		build_expected(kind == IMG_SHIFTED ? SHIFT * (255 / MAX_DISP)
			: (kind == IMG_FLAT ? 0 : -1));
		first = result_count;
		@(negedge HCLK);
		start = 1'b1;
		@(negedge HCLK);
		start = 1'b0;
		cycles = 0;
		while (!busy && cycles < RISE_LIMIT) begin
			@(negedge HCLK);
			cycles++;
		end
		assert (busy) else fail_run("engine did not become busy after start");
		if (extra_start) begin	// mid-frame pulse that the engine must ignore
			repeat (200) @(negedge HCLK);
			assert (busy) else fail_run("frame ended before the extra start pulse");
			start = 1'b1;
			@(negedge HCLK);
			start = 1'b0;
		end
		cycles = 0;
		while (busy && cycles < FRAME_LIMIT) begin
			// another pulse on the final result lands in the drain cycles
			start = extra_start && disp_out.valid && disp_out.frame_end;
			@(negedge HCLK);
			cycles++;
		end
		start = 1'b0;
		assert (!busy)
			else fail_run($sformatf("engine hung, busy still high after %0d cycles", FRAME_LIMIT));
		assert (result_count - first == NUM_RESULTS && expected.size() == 0)
			else fail_run($sformatf("** Error at %0t: %0d results, expected %0d",
				$time, result_count - first, NUM_RESULTS));
		for (int i = 0; i < 10; i++) begin	// no second frame may follow
			@(negedge HCLK);
			assert (!busy && !wb_req.cyc)
				else fail_run("engine started another frame after the frame ended");
		end
	endtask

	//----------------------------------------------------------
	// main sequence
	//----------------------------------------------------------
	initial begin
		start   = 1'b0;
		HRESETn = 1'b0;
		repeat (5) @(negedge HCLK);	// reset for 5 cycles
		HRESETn = 1'b1;
		for (int i = 0; i < 8; i++) begin	// idle before any start
			@(negedge HCLK);
			assert (!wb_req.cyc && !busy && !disp_out.valid)
				else fail_run($sformatf("** Error at %0t: cyc %0b busy %0b valid %0b before start",
					$time, wb_req.cyc, busy, disp_out.valid));
		end
		run_frame(IMG_SHIFTED, 1'b0);
		run_frame(IMG_RANDOM, 1'b1);
		run_frame(IMG_FLAT, 1'b0);	// all sums tie at zero
		run_frame(IMG_RANDOM, 1'b0);	// second start with new images
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
logic/wb_pkg.sv
logic/stereo_pkg.sv
logic/window_fetch.sv
logic/ssd_accum.sv
logic/disparity_select.sv
logic/stereo_match_top.sv
verif/image_mem_model.sv
verif/stereo_match_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the stereo matcher testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f project.f --top-module stereo_match_tb \
	-Mdir obj_dir -o stereo_match_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/stereo_match_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q -x "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
